//--- design/issue_cfg_pkg.sv
package issue_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // datapath widths

    localparam int PREG_WIDTH    = 6;  // physical register tag
    localparam int LREG_WIDTH    = 5;  // architectural register number
    localparam int ROB_IDX_WIDTH = 5;  // slot index, the wrap bit comes on top

    localparam int WB_PORTS      = 2;  // writeback ports on the wakeup bus

    ////////////////////////////////////////////////////////////////////////////
    // return-stack hints

    // ra and t0 are the link registers of the calling convention
    localparam logic [LREG_WIDTH-1:0] LINK_REG_A = 5'd1;
    localparam logic [LREG_WIDTH-1:0] LINK_REG_B = 5'd5;

endpackage

//--- design/issue_types_pkg.sv
package issue_types_pkg;

    typedef struct packed {
        logic                                    wrap;  // flips on every pass of the ROB
        logic [issue_cfg_pkg::ROB_IDX_WIDTH-1:0] idx;
    } rob_idx_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_COND,
        BR_JAL,
        BR_JALR
    } branch_op_e;

    typedef struct packed {
        rob_idx_t                                rob;
        logic [issue_cfg_pkg::PREG_WIDTH-1:0]    prd;
        logic [issue_cfg_pkg::PREG_WIDTH-1:0]    prs1;
        logic [issue_cfg_pkg::PREG_WIDTH-1:0]    prs2;
        logic [issue_cfg_pkg::LREG_WIDTH-1:0]    lrd;
        logic [issue_cfg_pkg::LREG_WIDTH-1:0]    lrs1;  // needed for the pop hint
        branch_op_e                              bop;
    } uop_t;

    typedef struct packed {
        logic rs1_rdy;
        logic rs2_rdy;
    } src_status_t;

    typedef enum logic [1:0] {
        BT_CONDITION,
        BT_DIRECT,
        BT_INDIRECT,
        BT_CALL
    } br_type_e;

    typedef enum logic [1:0] {
        RAS_NONE,
        RAS_PUSH,
        RAS_POP,
        RAS_POP_PUSH
    } ras_type_e;

    // true when a sits strictly before ref_idx in program order
    function automatic logic is_older(rob_idx_t a, rob_idx_t ref_idx);
        return (a.wrap ^ ref_idx.wrap) ^ (ref_idx.idx > a.idx);
    endfunction

endpackage

//--- design/issue_bank_if.sv
`timescale 1ns/1ns

interface issue_bank_if #(
    parameter int DEPTH = 4
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic                         wr_en;
    issue_types_pkg::uop_t        wr_uop;
    issue_types_pkg::src_status_t wr_status;
    logic                         sel_block;  // holds selection off for one cycle

    logic [CNT_W-1:0]             count;      // occupied entries
    logic                         full;
    logic                         sel_valid;
    issue_types_pkg::uop_t        sel_uop;

    modport ctrl (
        output wr_en, wr_uop, wr_status, sel_block,
        input  count, full
    );

    modport bank (
        input  wr_en, wr_uop, wr_status, sel_block,
        output count, full, sel_valid, sel_uop
    );

    modport out (
        input  sel_valid, sel_uop
    );

endinterface

//--- design/issue_ctrl.sv
`timescale 1ns/1ns

module issue_ctrl #(
    parameter int BANKS = 2,
    parameter int DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [BANKS-1:0]             dis_valid_i,
    input  issue_types_pkg::uop_t        dis_uop_i [BANKS],
    input  issue_types_pkg::src_status_t dis_status_i [BANKS],
    input  logic                         redirect_i,
    output logic                         full_o,
    issue_bank_if.ctrl                   banks [BANKS]
);

    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int RANK_W = (BANKS > 1) ? $clog2(BANKS) : 1;

    logic [CNT_W-1:0]  bank_cnt [BANKS];
    logic [BANKS-1:0]  bank_full;
    logic [RANK_W-1:0] rank_d [BANKS];
    logic [RANK_W-1:0] rank_q [BANKS];  // dispatch slot each bank takes

    ////////////////////////////////////////////////////////////////////////////
    // per-bank steering

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        assign bank_cnt[b]  = banks[b].count;
        assign bank_full[b] = banks[b].full;

        // the whole group waits while any bank is full
        assign banks[b].wr_en     = dis_valid_i[rank_q[b]] & ~full_o;
        assign banks[b].wr_uop    = dis_uop_i[rank_q[b]];
        assign banks[b].wr_status = dis_status_i[rank_q[b]];
        assign banks[b].sel_block = redirect_i;  // no issue while the flush lands
    end

    assign full_o = |bank_full;

    ////////////////////////////////////////////////////////////////////////////
    // occupancy order

    // rank of a bank is the number of banks that come before it when the
    // banks are lined up by count, lower bank number first on a tie
    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            rank_d[b] = '0;
            for (int j = 0; j < BANKS; j++) begin
                if ((bank_cnt[j] < bank_cnt[b]) ||
                    ((bank_cnt[j] == bank_cnt[b]) && (j < b))) begin
                    rank_d[b] = rank_d[b] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int b = 0; b < BANKS; b++) begin
                rank_q[b] <= RANK_W'(b);  // empty banks take slots in bank order
            end
        end else begin
            rank_q <= rank_d;  // order lags the counts by one cycle
        end
    end

endmodule

//--- design/issue_bank.sv
`timescale 1ns/1ns

module issue_bank #(
    parameter int DEPTH = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    issue_bank_if.bank                           bank,
    input  logic [issue_cfg_pkg::WB_PORTS-1:0]   wb_valid_i,
    input  logic [issue_cfg_pkg::PREG_WIDTH-1:0] wb_preg_i [issue_cfg_pkg::WB_PORTS],
    input  logic                                 redirect_i,
    input  issue_types_pkg::rob_idx_t            redirect_rob_i
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DEPTH-1:0]      valid_q;
    logic [DEPTH-1:0]      rdy1_q;
    logic [DEPTH-1:0]      rdy2_q;
    issue_types_pkg::uop_t uop_q [DEPTH];

    logic [DEPTH-1:0]      free_oh;
    logic [DEPTH-1:0]      ready;
    logic [DEPTH-1:0]      keep;
    logic [DEPTH-1:0]      wake1;
    logic [DEPTH-1:0]      wake2;
    logic                  in_wake1;
    logic                  in_wake2;
    logic                  in_keep;

    logic                  sel_found;
    logic                  sel_fire;
    logic [IDX_W-1:0]      sel_idx;
    logic                  sel_valid_q;
    issue_types_pkg::uop_t sel_uop_q;
    logic [CNT_W-1:0]      cnt;

    ////////////////////////////////////////////////////////////////////////////
    // wakeup and flush compare

    always_comb begin
        wake1    = '0;
        wake2    = '0;
        in_wake1 = 1'b0;
        in_wake2 = 1'b0;
        for (int p = 0; p < issue_cfg_pkg::WB_PORTS; p++) begin
            if (wb_valid_i[p]) begin
                for (int i = 0; i < DEPTH; i++) begin
                    wake1[i] = wake1[i] | (wb_preg_i[p] == uop_q[i].prs1);
                    wake2[i] = wake2[i] | (wb_preg_i[p] == uop_q[i].prs2);
                end
                // an op arriving on the same edge must not miss its wakeup
                in_wake1 = in_wake1 | (wb_preg_i[p] == bank.wr_uop.prs1);
                in_wake2 = in_wake2 | (wb_preg_i[p] == bank.wr_uop.prs2);
            end
        end
    end

    for (genvar i = 0; i < DEPTH; i++) begin : g_entry
        assign ready[i] = valid_q[i] & rdy1_q[i] & rdy2_q[i];
        assign keep[i]  = ~redirect_i | issue_types_pkg::is_older(uop_q[i].rob, redirect_rob_i);
    end

    assign in_keep = ~redirect_i | issue_types_pkg::is_older(bank.wr_uop.rob, redirect_rob_i);

    // lowest clear bit of valid_q
    assign free_oh = ~valid_q & (valid_q + 1'b1);

    ////////////////////////////////////////////////////////////////////////////
    // oldest-ready select

    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ready[i] &&
                (!sel_found || issue_types_pkg::is_older(uop_q[i].rob, uop_q[sel_idx].rob))) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    assign sel_fire = sel_found & ~bank.sel_block;

    ////////////////////////////////////////////////////////////////////////////
    // entry state

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q     <= '0;
            rdy1_q      <= '0;
            rdy2_q      <= '0;
            sel_valid_q <= 1'b0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (bank.wr_en && free_oh[i]) begin
                    valid_q[i] <= in_keep;
                    rdy1_q[i]  <= bank.wr_status.rs1_rdy | in_wake1;
                    rdy2_q[i]  <= bank.wr_status.rs2_rdy | in_wake2;
                end else begin
                    valid_q[i] <= valid_q[i] & keep[i] &
                                  ~(sel_fire && (sel_idx == IDX_W'(i)));
                    rdy1_q[i]  <= rdy1_q[i] | wake1[i];
                    rdy2_q[i]  <= rdy2_q[i] | wake2[i];
                end
            end
            sel_valid_q <= sel_fire;  // blocked on redirect, so nothing younger escapes
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (bank.wr_en && free_oh[i]) begin
                uop_q[i] <= bank.wr_uop;
            end
        end
        if (sel_fire) begin
            sel_uop_q <= uop_q[sel_idx];
        end
    end

    always_comb begin
        cnt = '0;
        for (int i = 0; i < DEPTH; i++) begin
            cnt = cnt + CNT_W'(valid_q[i]);
        end
    end

    assign bank.count     = cnt;
    assign bank.full      = &valid_q;
    assign bank.sel_valid = sel_valid_q;
    assign bank.sel_uop   = sel_uop_q;

endmodule

//--- design/issue_out_stage.sv
`timescale 1ns/1ns

module issue_out_stage (
    input  logic                          clk,
    input  logic                          rst,
    issue_bank_if.out                     side,
    input  logic                          redirect_i,
    input  issue_types_pkg::rob_idx_t     redirect_rob_i,
    output logic                          issue_valid_o,
    output issue_types_pkg::uop_t         issue_uop_o,
    output issue_types_pkg::br_type_e     issue_br_type_o,
    output issue_types_pkg::ras_type_e    issue_ras_type_o
);

    logic                       push;
    logic                       pop;
    logic                       keep;
    issue_types_pkg::br_type_e  br_type_d;
    issue_types_pkg::ras_type_e ras_type_d;

    assign push = (side.sel_uop.lrd == issue_cfg_pkg::LINK_REG_A) ||
                  (side.sel_uop.lrd == issue_cfg_pkg::LINK_REG_B);
    assign pop  = (side.sel_uop.lrs1 == issue_cfg_pkg::LINK_REG_A) ||
                  (side.sel_uop.lrs1 == issue_cfg_pkg::LINK_REG_B);

    assign keep = ~redirect_i | issue_types_pkg::is_older(side.sel_uop.rob, redirect_rob_i);

    ////////////////////////////////////////////////////////////////////////////
    // branch classification for the fetch side

    always_comb begin
        case ({push, pop})
            2'b10:   ras_type_d = issue_types_pkg::RAS_PUSH;
            2'b01:   ras_type_d = issue_types_pkg::RAS_POP;
            2'b11:   ras_type_d = issue_types_pkg::RAS_POP_PUSH;
            default: ras_type_d = issue_types_pkg::RAS_NONE;
        endcase

        case (side.sel_uop.bop)
            issue_types_pkg::BR_JAL: begin
                br_type_d = issue_types_pkg::BT_DIRECT;
            end
            issue_types_pkg::BR_JALR: begin
                // jalr touching a link register is a call or a return
                br_type_d = (push | pop) ? issue_types_pkg::BT_CALL
                                         : issue_types_pkg::BT_INDIRECT;
            end
            default: begin
                br_type_d = issue_types_pkg::BT_CONDITION;  // non-branches land here too
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= side.sel_valid & keep;
        end
    end

    always_ff @(posedge clk) begin
        issue_uop_o      <= side.sel_uop;
        issue_br_type_o  <= br_type_d;
        issue_ras_type_o <= ras_type_d;
    end

endmodule

//--- design/int_issue_queue.sv
`timescale 1ns/1ns

module int_issue_queue #(
    parameter int BANKS = 2,
    parameter int DEPTH = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [BANKS-1:0]                     dis_valid_i,
    input  issue_types_pkg::uop_t                dis_uop_i [BANKS],
    input  issue_types_pkg::src_status_t         dis_status_i [BANKS],
    output logic                                 full_o,
    input  logic [issue_cfg_pkg::WB_PORTS-1:0]   wb_valid_i,
    input  logic [issue_cfg_pkg::PREG_WIDTH-1:0] wb_preg_i [issue_cfg_pkg::WB_PORTS],
    input  logic                                 redirect_i,
    input  issue_types_pkg::rob_idx_t            redirect_rob_i,
    output logic [BANKS-1:0]                     issue_valid_o,
    output issue_types_pkg::uop_t                issue_uop_o [BANKS],
    output issue_types_pkg::br_type_e            issue_br_type_o [BANKS],
    output issue_types_pkg::ras_type_e           issue_ras_type_o [BANKS]
);

    issue_bank_if #(.DEPTH(DEPTH)) bank_if [BANKS] ();

    issue_ctrl #(
        .BANKS (BANKS),
        .DEPTH (DEPTH)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .dis_valid_i  (dis_valid_i),
        .dis_uop_i    (dis_uop_i),
        .dis_status_i (dis_status_i),
        .redirect_i   (redirect_i),
        .full_o       (full_o),
        .banks        (bank_if)
    );

    ////////////////////////////////////////////////////////////////////////////
    // one bank and one output register per issue port

    for (genvar b = 0; b < BANKS; b++) begin : g_port
        issue_bank #(
            .DEPTH (DEPTH)
        ) u_bank (
            .clk            (clk),
            .rst            (rst),
            .bank           (bank_if[b]),
            .wb_valid_i     (wb_valid_i),
            .wb_preg_i      (wb_preg_i),
            .redirect_i     (redirect_i),
            .redirect_rob_i (redirect_rob_i)
        );

        issue_out_stage u_out (
            .clk              (clk),
            .rst              (rst),
            .side             (bank_if[b]),
            .redirect_i       (redirect_i),
            .redirect_rob_i   (redirect_rob_i),
            .issue_valid_o    (issue_valid_o[b]),
            .issue_uop_o      (issue_uop_o[b]),
            .issue_br_type_o  (issue_br_type_o[b]),
            .issue_ras_type_o (issue_ras_type_o[b])
        );
    end

endmodule

//--- bench/tb_int_issue_queue.sv
`timescale 1ns/1ns

module tb_int_issue_queue #(
    parameter int BANKS = 2,
    parameter int DEPTH = 4
);

    localparam int WBP = issue_cfg_pkg::WB_PORTS;

    logic                                 clk;
    logic                                 rst;
    logic [BANKS-1:0]                     dis_valid;
    issue_types_pkg::uop_t                dis_uop [BANKS];
    issue_types_pkg::src_status_t         dis_status [BANKS];
    logic                                 full;
    logic [WBP-1:0]                       wb_valid;
    logic [issue_cfg_pkg::PREG_WIDTH-1:0] wb_preg [WBP];
    logic                                 redirect;
    issue_types_pkg::rob_idx_t            redirect_rob;
    logic [BANKS-1:0]                     issue_valid;
    issue_types_pkg::uop_t                issue_uop [BANKS];
    issue_types_pkg::br_type_e            issue_br_type [BANKS];
    issue_types_pkg::ras_type_e           issue_ras_type [BANKS];

    // scoreboard indexed by reorder index
    logic                                 live [64];
    logic                                 pend1 [64];
    logic                                 pend2 [64];
    issue_types_pkg::uop_t                sb_uop [64];
    logic                                 has_exp [64];
    logic [1:0]                           exp_bt [64];
    logic [1:0]                           exp_ras [64];
    logic                                 kill_pend;
    logic [5:0]                           kill_rob;
    int                                   errors;
    int                                   checks;
    int                                   timeouts;

    int_issue_queue #(.BANKS(BANKS), .DEPTH(DEPTH)) dut0 (
        .clk              (clk),
        .rst              (rst),
        .dis_valid_i      (dis_valid),
        .dis_uop_i        (dis_uop),
        .dis_status_i     (dis_status),
        .full_o           (full),
        .wb_valid_i       (wb_valid),
        .wb_preg_i        (wb_preg),
        .redirect_i       (redirect),
        .redirect_rob_i   (redirect_rob),
        .issue_valid_o    (issue_valid),
        .issue_uop_o      (issue_uop),
        .issue_br_type_o  (issue_br_type),
        .issue_ras_type_o (issue_ras_type)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // checking

    // a is older when the wrap bits differ XOR the reference slot is larger
    function automatic logic older(logic [5:0] a, logic [5:0] ref_rob);
        return (a[5] ^ ref_rob[5]) ^ (ref_rob[4:0] > a[4:0]);
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_outputs();
        int r;
        for (int b = 0; b < BANKS; b++) begin
            if (issue_valid[b] === 1'b1) begin
                r = int'(issue_uop[b].rob);
                checks++;
                assert (live[r]) else begin
                    errors++;
                    $display("bank %0d issued rob %h, which is not outstanding", b, r);
                end
                if (live[r]) begin
                    checks++;
                    assert (!pend1[r] && !pend2[r]) else begin
                        errors++;
                        $display("rob %h issued before its waiting source was woken", r);
                    end
                    check_value("issue_uop_o", 64'(issue_uop[b]), 64'(sb_uop[r]));
                    if (has_exp[r]) begin
                        check_value("issue_br_type_o", 64'(issue_br_type[b]), 64'(exp_bt[r]));
                        check_value("issue_ras_type_o", 64'(issue_ras_type[b]), 64'(exp_ras[r]));
                    end
                    live[r] = 1'b0;
                end
            end
        end
        if (kill_pend) begin  // the redirect lands on the coming edge
            for (int i = 0; i < 64; i++) begin
                if (live[i] && !older(6'(i), kill_rob)) begin
                    live[i] = 1'b0;
                end
            end
            kill_pend = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // driving

    task automatic clear_inputs();
        dis_valid    = '0;
        wb_valid     = '0;
        redirect     = 1'b0;
        redirect_rob = '0;
        for (int b = 0; b < BANKS; b++) begin
            dis_uop[b]    = '0;
            dis_status[b] = '0;
        end
        for (int p = 0; p < WBP; p++) begin
            wb_preg[p] = '0;
        end
    endtask

    task automatic step();
        @(negedge clk);
        check_outputs();
        @(posedge clk);
        #1;
        clear_inputs();
    endtask

    // records the staged group and wakeups, then spends one cycle
    task automatic fire();
        int r;
        for (int b = 0; b < BANKS; b++) begin
            if (dis_valid[b] && !full) begin
                r         = int'(dis_uop[b].rob);
                live[r]   = 1'b1;
                pend1[r]  = ~dis_status[b].rs1_rdy;
                pend2[r]  = ~dis_status[b].rs2_rdy;
                sb_uop[r] = dis_uop[b];
            end
        end
        for (int p = 0; p < WBP; p++) begin
            for (int i = 0; i < 64; i++) begin
                if (wb_valid[p] && live[i] && sb_uop[i].prs1 == wb_preg[p]) begin
                    pend1[i] = 1'b0;
                end
                if (wb_valid[p] && live[i] && sb_uop[i].prs2 == wb_preg[p]) begin
                    pend2[i] = 1'b0;
                end
            end
        end
        step();
    endtask

    function automatic int issuable_count();
        int n;
        n = 0;
        for (int i = 0; i < 64; i++) begin
            n += int'(live[i] && !pend1[i] && !pend2[i]);
        end
        return n;
    endfunction

    task automatic drain();
        int waited;
        waited = 0;
        while (issuable_count() != 0 && waited < 200) begin
            step();
            waited++;
        end
        assert (issuable_count() == 0) else begin
            errors++;
            timeouts++;
            $display("timeout: %0d ready ops were never issued", issuable_count());
        end
    endtask

    // DEPTH groups that never wake, then a ready group offered while full
    task automatic fill(int first, logic [5:0] tag);
        int r;
        r = first;
        for (int g = 0; g <= DEPTH; g++) begin
            if (g >= DEPTH - 1) begin
                check_value("full_o", 64'(full), 64'(g == DEPTH));
            end
            for (int b = 0; b < BANKS; b++) begin
                dis_valid[b]          = 1'b1;
                dis_uop[b].rob        = 6'(r);
                dis_uop[b].prs1       = tag;
                dis_uop[b].prs2       = tag;
                dis_status[b].rs1_rdy = (g == DEPTH);  // would issue if it got in
                dis_status[b].rs2_rdy = 1'b1;
                r++;
            end
            fire();
        end
        // a group taken while full would reach issue_valid_o within three cycles
        repeat (3) step();
    endtask

    initial begin
        int          fd;
        int          rc;
        int          arg [10];
        logic [7:0]  cmd;
        string       line;
        errors    = 0;
        checks    = 0;
        timeouts  = 0;
        kill_pend = 1'b0;
        kill_rob  = '0;
        for (int i = 0; i < 64; i++) begin
            live[i]    = 1'b0;
            pend1[i]   = 1'b0;
            pend2[i]   = 1'b0;
            has_exp[i] = 1'b0;
        end
        rst = 1'b1;
        clear_inputs();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("full_o", 64'(full), 64'd0);

        fd = $fopen("bench/issue_stimulus.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("could not open the stimulus file");
        end
        while (fd != 0 && !$feof(fd)) begin
            rc = $fscanf(fd, " %c", cmd);
            if (rc == 1) begin
                case (cmd)
                    "#": rc = $fgets(line, fd);
                    "S": begin
                        rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", arg[0], arg[1],
                                     arg[2], arg[3], arg[4], arg[5], arg[6], arg[7],
                                     arg[8], arg[9]);
                        if (arg[0] < BANKS) begin
                            dis_valid[arg[0]]          = 1'b1;
                            dis_uop[arg[0]].rob        = 6'(arg[1]);
                            dis_uop[arg[0]].prd        = 6'(arg[2]);
                            dis_uop[arg[0]].prs1       = 6'(arg[3]);
                            dis_uop[arg[0]].prs2       = 6'(arg[4]);
                            dis_uop[arg[0]].lrd        = 5'(arg[5]);
                            dis_uop[arg[0]].lrs1       = 5'(arg[6]);
                            dis_uop[arg[0]].bop        = issue_types_pkg::branch_op_e'(2'(arg[7]));
                            dis_status[arg[0]].rs1_rdy = arg[8][0];
                            dis_status[arg[0]].rs2_rdy = arg[9][0];
                        end
                    end
                    "W": begin
                        rc = $fscanf(fd, "%h %h", arg[0], arg[1]);
                        wb_valid[arg[0]] = 1'b1;
                        wb_preg[arg[0]]  = 6'(arg[1]);
                    end
                    "G": fire();
                    "R": begin
                        rc = $fscanf(fd, "%h", arg[0]);
                        redirect     = 1'b1;
                        redirect_rob = issue_types_pkg::rob_idx_t'(6'(arg[0]));
                        kill_pend    = 1'b1;
                        kill_rob     = 6'(arg[0]);
                        step();
                    end
                    "I": begin
                        rc = $fscanf(fd, "%h", arg[0]);
                        repeat (arg[0]) step();
                    end
                    "Q": drain();
                    "E": begin
                        rc = $fscanf(fd, "%h", arg[0]);
                        check_value("full_o", 64'(full), 64'(arg[0]));
                    end
                    "C": begin
                        rc = $fscanf(fd, "%h %h %h", arg[0], arg[1], arg[2]);
                        has_exp[arg[0]] = 1'b1;
                        exp_bt[arg[0]]  = 2'(arg[1]);
                        exp_ras[arg[0]] = 2'(arg[2]);
                    end
                    "F": begin
                        rc = $fscanf(fd, "%h %h", arg[0], arg[1]);
                        fill(arg[0], 6'(arg[1]));
                    end
                    default: begin
                        errors++;
                        $display("unknown stimulus command %c", cmd);
                    end
                endcase
            end
        end
        drain();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- bench/issue_stimulus.txt
# S slot rob prd prs1 prs2 lrd lrs1 bop rdy1 rdy2 | W port tag | G run staged cycle | R rob
# I cycles | Q drain | E full | C rob br_type ras_type | F first_rob tag   (values in hex)
I 3
E 0
C 01 1 1
C 03 3 2
C 04 3 3
S 0 01 10 02 03 01 00 2 1 1
S 1 02 11 04 05 00 00 0 1 1
G
S 0 03 12 06 07 00 01 3 1 1
S 1 04 13 08 09 05 05 3 1 1
G
Q
C 05 0 0
S 0 05 14 20 0a 00 00 1 0 1
S 1 06 15 21 22 00 00 0 0 0
W 0 20
G
I 6
W 0 21
G
I 6
W 1 22
G
C 07 2 0
C 08 3 1
S 0 07 16 24 0c 00 06 3 0 1
S 1 08 17 25 0d 01 00 3 0 1
G
S 0 09 18 0e 0f 00 00 0 1 1
S 1 0a 19 26 10 00 00 0 0 1
G
R 09
W 0 24
W 1 25
G
W 0 26
G
I 8
Q
F 10 3f
E 1
R 10
E 0
S 0 1a 1a 11 12 00 00 0 1 1
S 1 1b 1b 27 13 00 00 0 0 1
G
I 2
W 1 27
G
Q
I 6

//--- sources.f
design/issue_cfg_pkg.sv
design/issue_types_pkg.sv
design/issue_bank_if.sv
design/issue_ctrl.sv
design/issue_bank.sv
design/issue_out_stage.sv
design/int_issue_queue.sv
bench/tb_int_issue_queue.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_int_issue_queue
BANKS     ?= 2
DEPTH     ?= 4
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "make test    build with Verilator and run the testbench"
	@echo "make clean   remove the build directory"
	@echo "variables:   VERILATOR TOP BANKS DEPTH OBJ_DIR"

test:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-GBANKS=$(BANKS) -GDEPTH=$(DEPTH) -Mdir $(OBJ_DIR) -f sources.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
